// File: hw/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ============================================================
// Register file sizing.
// ============================================================

`define PHY_REGS        46
`define PHY_IDX_W       $clog2(`PHY_REGS)
`define CP_REGS         16

// ============================================================
// CPSR fields and coprocessor transfer encodings.
// ============================================================

`define CPSR_T          5
`define CPSR_MODE       4:0

// cond | 1110 | opc1 L | CRn | Rd | cp_num | opc2 1 | CRm
`define MRC_PATTERN     32'b????_1110_???1_????_????_????_???1_????
`define MCR_PATTERN     32'b????_1110_???0_????_????_????_???1_????

`endif

// File: hw/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

        typedef logic [`PHY_IDX_W-1:0] phy_idx_t;

        // CPSR mode field.
        typedef enum logic [4:0] {
                USR = 5'b10000,
                FIQ = 5'b10001,
                IRQ = 5'b10010,
                SVC = 5'b10011,
                ABT = 5'b10111,
                UND = 5'b11011,
                SYS = 5'b11111
        } cpu_mode_t;

        typedef enum logic {IDLE, BUSY} copro_state_t;

        typedef enum logic [1:0] {CP_IDLE, CP_ACCESS, CP_DONE, CP_WAIT_DROP} cp_state_t;

        typedef enum logic {OP_MCR = 1'b0, OP_MRC = 1'b1} copro_op_t; // Bit 20 of the word.

        // ============================================================
        // Physical register map.
        // ============================================================

        localparam phy_idx_t PHY_USR_R0   = 0;  // User R0..R14 follow.
        localparam phy_idx_t PHY_PC       = 15;
        localparam phy_idx_t PHY_FIQ_R8   = 16;
        localparam phy_idx_t PHY_FIQ_R9   = 17;
        localparam phy_idx_t PHY_FIQ_R10  = 18;
        localparam phy_idx_t PHY_FIQ_R11  = 19;
        localparam phy_idx_t PHY_FIQ_R12  = 20;
        localparam phy_idx_t PHY_FIQ_R13  = 21;
        localparam phy_idx_t PHY_FIQ_R14  = 22;
        localparam phy_idx_t PHY_IRQ_R13  = 23;
        localparam phy_idx_t PHY_IRQ_R14  = 24;
        localparam phy_idx_t PHY_SVC_R13  = 25;
        localparam phy_idx_t PHY_SVC_R14  = 26;
        localparam phy_idx_t PHY_ABT_R13  = 27;
        localparam phy_idx_t PHY_ABT_R14  = 28;
        localparam phy_idx_t PHY_UND_R13  = 29;
        localparam phy_idx_t PHY_UND_R14  = 30;
        localparam phy_idx_t PHY_CPSR     = 31;
        localparam phy_idx_t PHY_FIQ_SPSR = 32;
        localparam phy_idx_t PHY_IRQ_SPSR = 33;
        localparam phy_idx_t PHY_SVC_SPSR = 34;
        localparam phy_idx_t PHY_ABT_SPSR = 35;
        localparam phy_idx_t PHY_UND_SPSR = 36;

endpackage

// File: hw/decode_coproc.sv
`include "core_settings.svh"

module decode_coproc
        import core_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,

        input  logic [31:0]     i_instruction,
        input  logic            i_valid,
        input  logic [31:0]     i_cpsr_ff,
        input  logic            i_irq,
        input  logic            i_fiq,

        // Clears first, then freezes.
        input  logic            i_clear_from_writeback,
        input  logic            i_data_stall,
        input  logic            i_clear_from_alu,
        input  logic            i_stall_from_shifter,
        input  logic            i_stall_from_issue,

        input  logic            i_pipeline_dav,
        input  logic            i_copro_done,

        output logic            o_irq,
        output logic            o_fiq,
        output logic [31:0]     o_instruction,
        output logic            o_valid,
        output logic            o_stall_from_decode,

        output cpu_mode_t       o_copro_mode_ff,
        output logic            o_copro_dav_ff,
        output logic [31:0]     o_copro_word_ff,
        output phy_idx_t        o_copro_reg_ff
);

copro_state_t   state_ff;
copro_state_t   state_nxt;
logic           dav_nxt;
logic [31:0]    word_nxt;
phy_idx_t       reg_nxt;
cpu_mode_t      mode_nxt;
cpu_mode_t      cur_mode;
logic           is_copro;
logic           clear;
logic           freeze;

assign cur_mode = cpu_mode_t'(i_cpsr_ff[`CPSR_MODE]);
assign clear    = i_clear_from_writeback | i_clear_from_alu;
assign freeze   = i_data_stall | i_stall_from_shifter | i_stall_from_issue;

// Only ARM state transfers are taken.
assign is_copro = i_valid && !i_cpsr_ff[`CPSR_T] &&
                  ((i_instruction ==? `MRC_PATTERN) || (i_instruction ==? `MCR_PATTERN));

// ============================================================
// Rd to physical index.
// ============================================================

function automatic phy_idx_t translate(input logic [3:0] rd, input cpu_mode_t mode);
        phy_idx_t idx;

        idx = PHY_USR_R0 + phy_idx_t'(rd);

        case (mode)
        FIQ:
                case (rd)
                4'd8:    idx = PHY_FIQ_R8;
                4'd9:    idx = PHY_FIQ_R9;
                4'd10:   idx = PHY_FIQ_R10;
                4'd11:   idx = PHY_FIQ_R11;
                4'd12:   idx = PHY_FIQ_R12;
                4'd13:   idx = PHY_FIQ_R13;
                4'd14:   idx = PHY_FIQ_R14;
                default: ;
                endcase
        IRQ:
                if (rd == 4'd13)
                        idx = PHY_IRQ_R13;
                else if (rd == 4'd14)
                        idx = PHY_IRQ_R14;
        SVC:
                if (rd == 4'd13)
                        idx = PHY_SVC_R13;
                else if (rd == 4'd14)
                        idx = PHY_SVC_R14;
        ABT:
                if (rd == 4'd13)
                        idx = PHY_ABT_R13;
                else if (rd == 4'd14)
                        idx = PHY_ABT_R14;
        UND:
                if (rd == 4'd13)
                        idx = PHY_UND_R13;
                else if (rd == 4'd14)
                        idx = PHY_UND_R14;
        default: ; // USR and SYS share the user bank.
        endcase

        return idx;
endfunction

always_comb
begin
        state_nxt           = state_ff;
        dav_nxt             = o_copro_dav_ff;
        word_nxt            = o_copro_word_ff;
        reg_nxt             = o_copro_reg_ff;
        mode_nxt            = o_copro_mode_ff;
        o_stall_from_decode = 1'b0;
        o_instruction       = 32'd0;
        o_valid             = 1'b0;
        o_irq               = 1'b0;
        o_fiq               = 1'b0;

        case (state_ff)
        IDLE:
        begin
                if (is_copro)
                begin
                        o_stall_from_decode = 1'b1;
                        if (!i_pipeline_dav) // Pipeline drained.
                        begin
                                state_nxt = BUSY;
                                dav_nxt   = 1'b1;
                                word_nxt  = i_instruction;
                                reg_nxt   = translate(i_instruction[15:12], cur_mode);
                                mode_nxt  = cur_mode;
                        end
                end
                else
                begin
                        o_instruction = i_instruction;
                        o_valid       = i_valid;
                        o_irq         = i_irq;
                        o_fiq         = i_fiq;
                end
        end
        BUSY:
        begin
                o_stall_from_decode = !i_copro_done;
                if (i_copro_done)
                begin
                        state_nxt = IDLE;
                        dav_nxt   = 1'b0;
                        word_nxt  = 32'd0;
                        reg_nxt   = '0;
                end
        end
        default: ;
        endcase
end

always_ff @(posedge i_clk)
begin
        if (i_reset || clear)
        begin
                state_ff        <= IDLE;
                o_copro_dav_ff  <= 1'b0;
                o_copro_word_ff <= 32'd0;
                o_copro_reg_ff  <= '0;
                o_copro_mode_ff <= USR;
        end
        else if (!freeze)
        begin
                state_ff        <= state_nxt;
                o_copro_dav_ff  <= dav_nxt;
                o_copro_word_ff <= word_nxt;
                o_copro_reg_ff  <= reg_nxt;
                o_copro_mode_ff <= mode_nxt;
        end
end

a_no_dav_rise_busy: assert property (@(posedge i_clk) disable iff (i_reset)
        (state_ff == BUSY) |=> !$rose(o_copro_dav_ff));

endmodule

// File: hw/cp15_regs.sv
`include "core_settings.svh"

module cp15_regs
        import core_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,

        input  logic            i_dav,
        input  logic [31:0]     i_word,
        input  phy_idx_t        i_reg,

        input  logic            i_grant,
        input  logic [31:0]     i_rd_data,

        output logic            o_req,
        output logic            o_we,
        output phy_idx_t        o_index,
        output logic [31:0]     o_wr_data,
        output logic            o_done
);

cp_state_t      state_ff;
logic [31:0]    cp_regs [`CP_REGS];
copro_op_t      op;
logic [3:0]     crn;

assign op  = copro_op_t'(i_word[20]);
assign crn = i_word[19:16];

// ============================================================
// Register file access.
// ============================================================

// Request dropped if decode withdraws.
assign o_req     = (state_ff == CP_ACCESS) && i_dav;
assign o_we      = o_req && (op == OP_MRC);
assign o_index   = i_reg;
assign o_wr_data = cp_regs[crn];
assign o_done    = (state_ff == CP_DONE);

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_ff <= CP_IDLE;
                for (int i = 0; i < `CP_REGS; i++)
                begin
                        cp_regs[i] <= 32'd0;
                end
        end
        else
        begin
                case (state_ff)
                CP_IDLE:
                begin
                        if (i_dav)
                                state_ff <= CP_ACCESS;
                end
                CP_ACCESS:
                begin
                        if (!i_dav)
                        begin
                                state_ff <= CP_IDLE; // Aborted by a clear.
                        end
                        else if (i_grant)
                        begin
                                if (op == OP_MCR)
                                        cp_regs[crn] <= i_rd_data;
                                state_ff <= CP_DONE;
                        end
                end
                CP_DONE:
                begin
                        state_ff <= CP_WAIT_DROP;
                end
                CP_WAIT_DROP:
                begin
                        if (!i_dav) // Decode has seen done.
                                state_ff <= CP_IDLE;
                end
                default:
                begin
                        state_ff <= CP_IDLE;
                end
                endcase
        end
end

a_done_one_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        o_done |=> !o_done);

endmodule

// File: hw/regfile_arbiter.sv
`include "core_settings.svh"

module regfile_arbiter
        import core_pkg::*;
(
        // Writeback side.
        input  logic            i_wb_en,
        input  phy_idx_t        i_wb_index,
        input  logic [31:0]     i_wb_data,

        // Coprocessor side.
        input  logic            i_cp_req,
        input  logic            i_cp_we,
        input  phy_idx_t        i_cp_index,
        input  logic [31:0]     i_cp_wr_data,
        output logic            o_cp_grant,
        output logic [31:0]     o_cp_rd_data,

        // Register file port.
        input  logic [31:0]     i_rf_rd_data,
        output logic            o_rf_en,
        output logic            o_rf_we,
        output phy_idx_t        o_rf_index,
        output logic [31:0]     o_rf_wr_data
);

logic wb_grant;

// Writeback always wins.
assign wb_grant   = i_wb_en;
assign o_cp_grant = i_cp_req && !wb_grant;

assign o_rf_en      = wb_grant | o_cp_grant;
assign o_rf_we      = wb_grant | (o_cp_grant & i_cp_we);
assign o_rf_index   = wb_grant ? i_wb_index : i_cp_index;
assign o_rf_wr_data = wb_grant ? i_wb_data  : i_cp_wr_data;

assign o_cp_rd_data = o_cp_grant ? i_rf_rd_data : 32'd0;

a_one_grant: assert final (!(wb_grant && o_cp_grant));

endmodule

// File: hw/banked_regfile.sv
`include "core_settings.svh"

module banked_regfile
        import core_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,

        input  logic            i_en,
        input  logic            i_we,
        input  phy_idx_t        i_index,
        input  logic [31:0]     i_wr_data,
        output logic [31:0]     o_rd_data,

        input  phy_idx_t        i_rd_index,
        output logic [31:0]     o_rd_data_b  // Pipeline read port.
);

logic [31:0] regs [`PHY_REGS];

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                for (int i = 0; i < `PHY_REGS; i++)
                begin
                        regs[i] <= 32'd0;
                end
        end
        else if (i_en && i_we)
        begin
                regs[i_index] <= i_wr_data;
        end
end

assign o_rd_data   = (i_en && i_index < `PHY_REGS) ? regs[i_index] : 32'd0;
assign o_rd_data_b = (i_rd_index < `PHY_REGS) ? regs[i_rd_index] : 32'd0;

endmodule

// File: hw/copro_subsystem_top.sv
`include "core_settings.svh"

module copro_subsystem_top
        import core_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic [31:0]     i_instruction,
        input  logic            i_valid,
        input  logic [31:0]     i_cpsr_ff,
        input  logic            i_irq,
        input  logic            i_fiq,
        input  logic            i_clear_from_writeback,
        input  logic            i_data_stall,
        input  logic            i_clear_from_alu,
        input  logic            i_stall_from_shifter,
        input  logic            i_stall_from_issue,
        input  logic            i_pipeline_dav,

        input  logic            i_wb_en,
        input  phy_idx_t        i_wb_index,
        input  logic [31:0]     i_wb_data,
        input  phy_idx_t        i_rd_index,

        output logic            o_irq,
        output logic            o_fiq,
        output logic [31:0]     o_instruction,
        output logic            o_valid,
        output logic            o_stall_from_decode,
        output cpu_mode_t       o_copro_mode_ff,
        output logic            o_copro_dav_ff,
        output logic [31:0]     o_copro_word_ff,
        output phy_idx_t        o_copro_reg_ff,
        output logic [31:0]     o_rd_data
);

logic           cp_done;
logic           cp_req;
logic           cp_we;
phy_idx_t       cp_index;
logic [31:0]    cp_wr_data;
logic           cp_grant;
logic [31:0]    cp_rd_data;
logic           rf_en;
logic           rf_we;
phy_idx_t       rf_index;
logic [31:0]    rf_wr_data;
logic [31:0]    rf_rd_data;

decode_coproc u_decode_coproc (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_instruction          (i_instruction),
        .i_valid                (i_valid),
        .i_cpsr_ff              (i_cpsr_ff),
        .i_irq                  (i_irq),
        .i_fiq                  (i_fiq),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_shifter   (i_stall_from_shifter),
        .i_stall_from_issue     (i_stall_from_issue),
        .i_pipeline_dav         (i_pipeline_dav),
        .i_copro_done           (cp_done),
        .o_irq                  (o_irq),
        .o_fiq                  (o_fiq),
        .o_instruction          (o_instruction),
        .o_valid                (o_valid),
        .o_stall_from_decode    (o_stall_from_decode),
        .o_copro_mode_ff        (o_copro_mode_ff),
        .o_copro_dav_ff         (o_copro_dav_ff),
        .o_copro_word_ff        (o_copro_word_ff),
        .o_copro_reg_ff         (o_copro_reg_ff)
);

cp15_regs u_cp15_regs (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_dav          (o_copro_dav_ff),
        .i_word         (o_copro_word_ff),
        .i_reg          (o_copro_reg_ff),
        .i_grant        (cp_grant),
        .i_rd_data      (cp_rd_data),
        .o_req          (cp_req),
        .o_we           (cp_we),
        .o_index        (cp_index),
        .o_wr_data      (cp_wr_data),
        .o_done         (cp_done)
);

regfile_arbiter u_regfile_arbiter (
        .i_wb_en        (i_wb_en),
        .i_wb_index     (i_wb_index),
        .i_wb_data      (i_wb_data),
        .i_cp_req       (cp_req),
        .i_cp_we        (cp_we),
        .i_cp_index     (cp_index),
        .i_cp_wr_data   (cp_wr_data),
        .o_cp_grant     (cp_grant),
        .o_cp_rd_data   (cp_rd_data),
        .i_rf_rd_data   (rf_rd_data),
        .o_rf_en        (rf_en),
        .o_rf_we        (rf_we),
        .o_rf_index     (rf_index),
        .o_rf_wr_data   (rf_wr_data)
);

banked_regfile u_banked_regfile (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_en           (rf_en),
        .i_we           (rf_we),
        .i_index        (rf_index),
        .i_wr_data      (rf_wr_data),
        .o_rd_data      (rf_rd_data),
        .i_rd_index     (i_rd_index),
        .o_rd_data_b    (o_rd_data)
);

endmodule

// File: verification/tb_copro_ref.svh
`ifndef TB_COPRO_REF_SVH
`define TB_COPRO_REF_SVH

// ============================================================
// Reference model state.
// ============================================================

logic [31:0] cpu_shadow [`PHY_REGS];
logic [31:0] cp_shadow  [`CP_REGS];

cpu_mode_t mode_list [7] = '{USR, FIQ, IRQ, SVC, ABT, UND, SYS};

function automatic void clear_shadows();
        foreach (cpu_shadow[i]) cpu_shadow[i] = 32'd0;
        foreach (cp_shadow[i]) cp_shadow[i] = 32'd0;
endfunction

// Architectural Rd to physical index.
function automatic phy_idx_t translate_rd(input logic [3:0] rd, input cpu_mode_t mode);
        int base;
        if (mode == FIQ && rd >= 4'd8 && rd <= 4'd14)
                return phy_idx_t'(16 + rd - 8); // FIQ R8..R14 at 16.
        case (mode)
        IRQ:     base = 23;
        SVC:     base = 25;
        ABT:     base = 27;
        UND:     base = 29;
        default: base = 0;
        endcase
        if (base != 0 && (rd == 4'd13 || rd == 4'd14))
                return phy_idx_t'(base + rd - 13);
        return phy_idx_t'(rd);
endfunction

// cond AL, opc1 0, cp15, opc2 0, CRm 0.
function automatic logic [31:0] encode_transfer(input copro_op_t op, input logic [3:0] crn,
                                                input logic [3:0] rd);
        return {4'hE, 4'b1110, 3'b000, op, crn, rd, 4'hF, 3'b000, 1'b1, 4'h0};
endfunction

function automatic bit is_transfer_word(input logic [31:0] word);
        return (word[27:24] == 4'b1110) && word[4];
endfunction

`endif

// File: verification/tb_copro_subsystem.sv
`include "core_settings.svh"

module tb_copro_subsystem
        import core_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

`include "tb_copro_ref.svh"

localparam int N_ARM_PASS     = 40;
localparam int N_THUMB_PASS   = 20;
localparam int N_BANK         = 8;
localparam int N_PRESSURE     = 8;
localparam int NUM_TESTS      = N_ARM_PASS + N_THUMB_PASS + 3 * 7 + 3 * N_BANK + 3
                                + 2 * N_PRESSURE + 31 + 4;
localparam int TIMEOUT_CYCLES = 40 * NUM_TESTS + 200;

logic           i_clk = 1'b0;
logic           i_reset;
logic [31:0]    i_instruction;
logic           i_valid;
logic [31:0]    i_cpsr_ff;
logic           i_irq;
logic           i_fiq;
logic           i_clear_from_writeback;
logic           i_data_stall;
logic           i_clear_from_alu;
logic           i_stall_from_shifter;
logic           i_stall_from_issue;
logic           i_pipeline_dav;
logic           i_wb_en;
phy_idx_t       i_wb_index;
logic [31:0]    i_wb_data;
phy_idx_t       i_rd_index;

logic           o_irq;
logic           o_fiq;
logic [31:0]    o_instruction;
logic           o_valid;
logic           o_stall_from_decode;
cpu_mode_t      o_copro_mode_ff;
logic           o_copro_dav_ff;
logic [31:0]    o_copro_word_ff;
phy_idx_t       o_copro_reg_ff;
logic [31:0]    o_rd_data;

logic           exp_en = 1'b0;
logic [31:0]    exp_instr;
logic           exp_valid;
logic           exp_irq;
logic           exp_fiq;
int             cycle_count = 0;

copro_subsystem_top u_copro_subsystem_top (.*);

always #20 i_clk = ~i_clk;

// ============================================================
// Failure reporting and compare tasks.
// ============================================================

task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on the first error.");
endtask

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
                stop_with_failure($sformatf("MISMATCH at %0t: %s expected %h, got %h",
                                            $time, name, exp, act));
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
                stop_with_failure($sformatf("MISMATCH at %0t: %s expected %b, got %b",
                                            $time, name, exp, act));
endtask

task automatic check_mode(input string name, input cpu_mode_t exp, input cpu_mode_t act);
        if (act !== exp)
                stop_with_failure($sformatf("MISMATCH at %0t: %s expected %s, got %s (%b)",
                                            $time, name, exp.name(), act.name(), act));
endtask

task automatic check_index(input string name, input phy_idx_t exp, input phy_idx_t act);
        if (act !== exp)
                stop_with_failure($sformatf("MISMATCH at %0t: %s expected %0d, got %0d",
                                            $time, name, exp, act));
endtask

// Pass-through outputs, mid low phase.
always
begin
        @(negedge i_clk);
        #10;
        if (exp_en)
        begin
                check_word("o_instruction", exp_instr, o_instruction);
                check_flag("o_valid", exp_valid, o_valid);
                check_flag("o_irq", exp_irq, o_irq);
                check_flag("o_fiq", exp_fiq, o_fiq);
                check_flag("o_stall_from_decode", 1'b0, o_stall_from_decode);
        end
end

always @(posedge i_clk)
begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES)
                stop_with_failure($sformatf("Timeout: test still running after %0d cycles.",
                                            cycle_count));
end

// ============================================================
// Stimulus tasks.
// ============================================================

task automatic pass_through(input int count, input bit thumb);
        logic [31:0] word;
        for (int n = 0; n < count; n++)
        begin
                @(negedge i_clk);
                word = $urandom;
                if (thumb)
                        word = encode_transfer(copro_op_t'($urandom_range(1, 0)),
                                               4'($urandom), 4'($urandom));
                else if (is_transfer_word(word))
                        word[4] = 1'b0;
                i_instruction = word;
                i_valid       = 1'($urandom_range(1, 0));
                i_cpsr_ff     = {26'd0, thumb, mode_list[$urandom_range(6, 0)]};
                i_irq         = 1'($urandom_range(1, 0));
                i_fiq         = 1'($urandom_range(1, 0));
                exp_instr     = word;
                exp_valid     = i_valid;
                exp_irq       = i_irq;
                exp_fiq       = i_fiq;
                exp_en        = 1'b1;
        end
        @(negedge i_clk);
        exp_en  = 1'b0;
        i_valid = 1'b0;
        i_irq   = 1'b0;
        i_fiq   = 1'b0;
endtask

task automatic preload_regs();
        for (int i = 0; i <= 30; i++)
        begin
                @(negedge i_clk);
                i_wb_en       = 1'b1;
                i_wb_index    = phy_idx_t'(i);
                i_wb_data     = $urandom;
                cpu_shadow[i] = i_wb_data;
        end
        @(negedge i_clk);
        i_wb_en = 1'b0;
endtask

// Random writeback, never to the transfer's own register.
task automatic drive_traffic(input bit enable, input phy_idx_t avoid);
        int idx;
        if (enable && $urandom_range(1, 0) == 1)
        begin
                idx = $urandom_range(30, 0);
                if (idx == avoid)
                        idx = (idx + 1) % 31;
                i_wb_en         = 1'b1;
                i_wb_index      = phy_idx_t'(idx);
                i_wb_data       = $urandom;
                cpu_shadow[idx] = i_wb_data;
        end
        else
        begin
                i_wb_en = 1'b0;
        end
endtask

task automatic run_transfer(input copro_op_t op, input cpu_mode_t mode, input logic [3:0] rd,
                            input logic [3:0] crn, input int drain, input bit traffic);
        phy_idx_t    idx;
        logic [31:0] word;
        idx  = translate_rd(rd, mode);
        word = encode_transfer(op, crn, rd);
        @(negedge i_clk);
        i_instruction  = word;
        i_valid        = 1'b1;
        i_cpsr_ff      = {27'd0, mode}; // ARM state.
        i_pipeline_dav = (drain > 0);
        i_rd_index     = idx;
        for (int n = 0; n < drain; n++)
        begin
                @(negedge i_clk);
                check_flag("o_stall_from_decode", 1'b1, o_stall_from_decode);
                check_flag("o_copro_dav_ff", 1'b0, o_copro_dav_ff);
                check_word("o_rd_data", cpu_shadow[idx], o_rd_data);
        end
        i_pipeline_dav = 1'b0;
        @(negedge i_clk);
        check_flag("o_copro_dav_ff", 1'b1, o_copro_dav_ff);
        check_flag("o_stall_from_decode", 1'b1, o_stall_from_decode);
        check_word("o_copro_word_ff", word, o_copro_word_ff);
        check_index("o_copro_reg_ff", idx, o_copro_reg_ff);
        check_mode("o_copro_mode_ff", mode, o_copro_mode_ff);
        while (o_stall_from_decode)
        begin
                drive_traffic(traffic, idx);
                @(negedge i_clk);
        end
        i_wb_en       = 1'b0;
        i_valid       = 1'b0;
        i_instruction = 32'd0;
        if (op == OP_MCR)
                cp_shadow[crn] = cpu_shadow[idx];
        else
                cpu_shadow[idx] = cp_shadow[crn];
endtask

task automatic read_reg(input phy_idx_t idx);
        @(negedge i_clk);
        i_rd_index = idx;
        @(negedge i_clk);
        check_word($sformatf("o_rd_data[%0d]", idx), cpu_shadow[idx], o_rd_data);
endtask

task automatic clear_while_stalled();
        @(negedge i_clk);
        i_instruction = encode_transfer(OP_MRC, 4'd3, 4'd14);
        i_valid       = 1'b1;
        i_cpsr_ff     = {27'd0, SVC};
        @(negedge i_clk);
        check_flag("o_stall_from_decode", 1'b1, o_stall_from_decode);
        i_clear_from_alu = 1'b1;
        i_instruction    = 32'he1a0_0000; // MOV r0, r0.
        @(negedge i_clk);
        i_clear_from_alu = 1'b0;
        check_flag("o_copro_dav_ff", 1'b0, o_copro_dav_ff);
        exp_instr = 32'he1a0_0000;
        exp_valid = 1'b1;
        exp_irq   = 1'b0;
        exp_fiq   = 1'b0;
        exp_en    = 1'b1;
        @(negedge i_clk);
        exp_en  = 1'b0;
        i_valid = 1'b0;
        read_reg(translate_rd(4'd14, SVC)); // Aborted MRC wrote nothing.
endtask

// ============================================================
// Test sequence.
// ============================================================

initial
begin
        cpu_mode_t  mode;
        logic [3:0] rd;
        logic [3:0] crn;

        void'($urandom(32'ha0a3_849e));
        i_reset                = 1'b1;
        i_instruction          = 32'd0;
        i_valid                = 1'b0;
        i_cpsr_ff              = {27'd0, USR};
        i_irq                  = 1'b0;
        i_fiq                  = 1'b0;
        i_clear_from_writeback = 1'b0;
        i_data_stall           = 1'b0;
        i_clear_from_alu       = 1'b0;
        i_stall_from_shifter   = 1'b0;
        i_stall_from_issue     = 1'b0;
        i_pipeline_dav         = 1'b0;
        i_wb_en                = 1'b0;
        i_wb_index             = '0;
        i_wb_data              = 32'd0;
        i_rd_index             = '0;
        clear_shadows();

        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;
        @(negedge i_clk);
        check_flag("o_copro_dav_ff", 1'b0, o_copro_dav_ff);
        check_flag("o_stall_from_decode", 1'b0, o_stall_from_decode);
        check_flag("o_valid", 1'b0, o_valid);

        pass_through(N_ARM_PASS, 1'b0);
        pass_through(N_THUMB_PASS, 1'b1);

        preload_regs();
        foreach (mode_list[m])
        begin
                rd  = 4'($urandom);
                crn = 4'($urandom);
                run_transfer(OP_MCR, mode_list[m], rd, crn, 0, 1'b0);
                run_transfer(OP_MRC, USR, 4'd0, crn, 0, 1'b0);
                read_reg(PHY_USR_R0);
        end

        for (int n = 0; n < N_BANK; n++)
        begin
                run_transfer(OP_MCR, mode_list[$urandom_range(6, 0)], 4'($urandom),
                             4'($urandom), 0, 1'b0);
                mode = mode_list[$urandom_range(6, 0)];
                rd   = 4'($urandom);
                run_transfer(OP_MRC, mode, rd, 4'($urandom), 0, 1'b0);
                read_reg(translate_rd(rd, mode));
        end

        run_transfer(OP_MRC, IRQ, 4'd13, 4'($urandom), 5, 1'b0);
        read_reg(PHY_IRQ_R13);
        run_transfer(OP_MCR, FIQ, 4'd9, 4'($urandom), 3, 1'b0);

        for (int n = 0; n < N_PRESSURE; n++)
        begin
                run_transfer(OP_MCR, mode_list[$urandom_range(6, 0)], 4'($urandom),
                             4'($urandom), 0, 1'b1);
                run_transfer(OP_MRC, mode_list[$urandom_range(6, 0)], 4'($urandom),
                             4'($urandom), 0, 1'b1);
        end
        for (int i = 0; i <= 30; i++)
                read_reg(phy_idx_t'(i));

        clear_while_stalled();
        run_transfer(OP_MRC, UND, 4'd14, 4'd3, 0, 1'b0);
        read_reg(PHY_UND_R14);

        @(negedge i_clk);
        $display("STATUS: PASS");
        $finish;
end

endmodule

// File: all.f
+incdir+hw
+incdir+verification
hw/core_pkg.sv
hw/decode_coproc.sv
hw/cp15_regs.sv
hw/regfile_arbiter.sv
hw/banked_regfile.sv
hw/copro_subsystem_top.sv
verification/tb_copro_subsystem.sv

// File: Bender.yml
package:
  name: copro_subsystem

sources:
  - include_dirs:
      - hw
    files:
      - hw/core_pkg.sv
      - hw/decode_coproc.sv
      - hw/cp15_regs.sv
      - hw/regfile_arbiter.sv
      - hw/banked_regfile.sv
      - hw/copro_subsystem_top.sv
  - target: test
    include_dirs:
      - hw
      - verification
    files:
      - verification/tb_copro_subsystem.sv
